// ==== source/key_extract_pkg.sv ====
package key_extract_pkg;

    // ========================================
    // widths
    // ========================================
    localparam int CONT2_W   = 16;
    localparam int CONT4_W   = 32;
    localparam int CONT6_W   = 48;
    localparam int NUM_CONT  = 8;
    localparam int META_W    = 256;
    localparam int VID_W     = 12;
    localparam int CMP_W     = 8;
    localparam int TBL_IDX_W = 5;
    localparam int KEY_W     = 2 * CONT6_W + 2 * CONT4_W + 2 * CONT2_W + 1;

    // lowest vid bit used as table index
    localparam int VID_INDEX_LSB = 4;

    typedef logic [CONT2_W-1:0]           cont2_t;
    typedef logic [CONT4_W-1:0]           cont4_t;
    typedef logic [CONT6_W-1:0]           cont6_t;
    typedef logic [$clog2(NUM_CONT)-1:0]  cont_sel_t;
    typedef logic [VID_W-1:0]             vid_t;
    typedef logic [KEY_W-1:0]             key_t;
    typedef logic [TBL_IDX_W-1:0]         tbl_idx_t;
    typedef logic [CMP_W-1:0]             cmp_byte_t;

    // ========================================
    // packet header vector and key layout
    // ========================================
    // index 7 of each container group sits at the top
    typedef struct packed {
        cont6_t [NUM_CONT-1:0] cont6;
        cont4_t [NUM_CONT-1:0] cont4;
        cont2_t [NUM_CONT-1:0] cont2;
        logic [META_W-1:0]     meta;
    } phv_t;

    typedef struct packed {
        cont6_t six_a;
        cont6_t six_b;
        cont4_t four_a;
        cont4_t four_b;
        cont2_t two_a;
        cont2_t two_b;
        logic   cmp_bit;
    } key_fields_t;

    // ========================================
    // table entries
    // ========================================
    typedef enum logic [1:0] {
        CMP_GT   = 2'd0,
        CMP_GE   = 2'd1,
        CMP_EQ   = 2'd2,
        CMP_TRUE = 2'd3
    } cmp_op_e;

    typedef enum logic [1:0] {
        KIND_2B   = 2'd0,
        KIND_4B   = 2'd1,
        KIND_6B   = 2'd2,
        KIND_NONE = 2'd3
    } cont_kind_e;

    // payload[4:3] kind, payload[2:0] container, unless immediate
    typedef struct packed {
        logic      is_imm;
        cmp_byte_t payload;
    } cmp_operand_t;

    typedef struct packed {
        cmp_op_e      op;
        cmp_operand_t operand_1;
        cmp_operand_t operand_2;
    } cmp_cfg_t;

    typedef struct packed {
        cont_sel_t sel_six_a;
        cont_sel_t sel_six_b;
        cont_sel_t sel_four_a;
        cont_sel_t sel_four_b;
        cont_sel_t sel_two_a;
        cont_sel_t sel_two_b;
        cmp_cfg_t  cmp;
    } key_off_t;

    typedef struct packed {
        logic     wr_off;
        logic     wr_mask;
        tbl_idx_t index;
        key_off_t off;
        key_t     mask;
    } tbl_wr_t;

    // ========================================
    // items between stages
    // ========================================
    typedef struct packed {
        phv_t     phv;
        key_off_t off;
        key_t     mask;
    } decode_item_t;

    typedef struct packed {
        phv_t phv;
        key_t key;
        key_t mask;
    } result_item_t;

endpackage

// ==== source/key_table.sv ====
`timescale 1ns/1ps

module key_table
    import key_extract_pkg::*;
#(
    parameter int TABLE_DEPTH = 32
) (
    input  logic     clk,
    input  logic     rst_n,
    input  tbl_wr_t  tbl_wr,
    input  tbl_idx_t rd_index,
    output key_off_t rd_off,
    output key_t     rd_mask
);

    localparam int ADDR_W = (TABLE_DEPTH > 1) ? $clog2(TABLE_DEPTH) : 1;
    localparam int DEPTH  = 2 ** ADDR_W;

    key_off_t          off_mem  [DEPTH];
    key_t              mask_mem [DEPTH];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign wr_addr = tbl_wr.index[ADDR_W-1:0];
    assign rd_addr = rd_index[ADDR_W-1:0];

    // ========================================
    // write port
    // ========================================
    // no writes land while reset is held
    always_ff @(posedge clk) begin
        if (rst_n && tbl_wr.wr_off) begin
            off_mem[wr_addr] <= tbl_wr.off;
        end
        if (rst_n && tbl_wr.wr_mask) begin
            mask_mem[wr_addr] <= tbl_wr.mask;
        end
    end

    // ========================================
    // read port
    // ========================================
    // registered read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        rd_off  <= off_mem[rd_addr];
        rd_mask <= mask_mem[rd_addr];
    end

endmodule

// ==== source/key_decode.sv ====
`timescale 1ns/1ps

module key_decode
    import key_extract_pkg::*;
#(
    parameter int TABLE_DEPTH = 32
) (
    input  logic         clk,
    input  logic         rst_n,
    input  phv_t         phv_in,
    input  logic         phv_valid_in,
    output logic         ready_out,
    input  vid_t         vid_in,
    input  logic         vid_empty,
    output logic         vid_rd_en,
    input  tbl_wr_t      tbl_wr,
    input  logic         exe_full,
    output logic         dec_valid,
    output decode_item_t dec_item
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        ACCEPT
    } state_e;

    state_e   state;
    state_e   state_next;
    tbl_idx_t rd_index;
    key_off_t rd_off;
    key_t     rd_mask;
    logic     accept;

    // index bits of the vid at the fifo head
    assign rd_index = vid_in[VID_INDEX_LSB +: TBL_IDX_W];

    key_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_key_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .tbl_wr   (tbl_wr),
        .rd_index (rd_index),
        .rd_off   (rd_off),
        .rd_mask  (rd_mask)
    );

    assign ready_out = (state == ACCEPT) && !exe_full;
    assign accept    = ready_out && phv_valid_in;
    // pop the vid in the same cycle the phv is taken
    assign vid_rd_en = accept;

    // ========================================
    // control FSM
    // ========================================
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (!vid_empty) begin
                    state_next = LOOKUP;
                end
            end
            // table read in flight
            LOOKUP: begin
                state_next = ACCEPT;
            end
            ACCEPT: begin
                if (accept) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            dec_valid <= 1'b0;
        end else begin
            state     <= state_next;
            dec_valid <= accept;
        end
    end

    // phv plus entry for the execute stage
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_item.phv  <= phv_in;
            dec_item.off  <= rd_off;
            dec_item.mask <= rd_mask;
        end
    end

endmodule

// ==== source/key_execute.sv ====
`timescale 1ns/1ps

module key_execute
    import key_extract_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         dec_valid,
    input  decode_item_t dec_item,
    input  logic         res_full,
    output logic         exe_full,
    output logic         exe_valid,
    output result_item_t exe_item
);

    phv_t        phv;
    key_off_t    off;
    cmp_byte_t   opd_1;
    cmp_byte_t   opd_2;
    logic        cmp_bit;
    key_fields_t fields;

    assign phv = dec_item.phv;
    assign off = dec_item.off;

    // immediate, or low byte of the selected container
    function automatic cmp_byte_t fetch_operand(cmp_operand_t opd, phv_t p);
        cont_kind_e kind;
        cont_sel_t  sel;
        cmp_byte_t  val;
        kind = cont_kind_e'(opd.payload[4:3]);
        sel  = opd.payload[2:0];
        if (opd.is_imm) begin
            val = opd.payload;
        end else begin
            case (kind)
                KIND_2B: val = p.cont2[sel][CMP_W-1:0];
                KIND_4B: val = p.cont4[sel][CMP_W-1:0];
                KIND_6B: val = p.cont6[sel][CMP_W-1:0];
                default: val = '0;
            endcase
        end
        return val;
    endfunction

    // ========================================
    // comparator
    // ========================================
    assign opd_1 = fetch_operand(off.cmp.operand_1, phv);
    assign opd_2 = fetch_operand(off.cmp.operand_2, phv);

    always_comb begin
        case (off.cmp.op)
            CMP_GT:  cmp_bit = (opd_1 > opd_2);
            CMP_GE:  cmp_bit = (opd_1 >= opd_2);
            CMP_EQ:  cmp_bit = (opd_1 == opd_2);
            default: cmp_bit = 1'b1;
        endcase
    end

    // ========================================
    // key assembly
    // ========================================
    always_comb begin
        fields.six_a   = phv.cont6[off.sel_six_a];
        fields.six_b   = phv.cont6[off.sel_six_b];
        fields.four_a  = phv.cont4[off.sel_four_a];
        fields.four_b  = phv.cont4[off.sel_four_b];
        fields.two_a   = phv.cont2[off.sel_two_a];
        fields.two_b   = phv.cont2[off.sel_two_b];
        fields.cmp_bit = cmp_bit;
    end

    // item leaves once the result stage has room
    assign exe_valid = exe_full && !res_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_full <= 1'b0;
        end else if (dec_valid) begin
            exe_full <= 1'b1;
        end else if (exe_valid) begin
            exe_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_item.phv  <= phv;
            exe_item.key  <= key_t'(fields);
            exe_item.mask <= dec_item.mask;
        end
    end

endmodule

// ==== source/key_result.sv ====
`timescale 1ns/1ps

module key_result
    import key_extract_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         exe_valid,
    input  result_item_t exe_item,
    input  logic         ready_in,
    output logic         res_full,
    output phv_t         phv_out,
    output logic         phv_valid_out,
    output key_t         key_out,
    output logic         key_valid_out
);

    logic drain;
    key_t masked_key;

    // set mask bits clear the key bit
    assign masked_key = exe_item.key & ~exe_item.mask;

    // ========================================
    // output handshake
    // ========================================
    assign drain         = res_full && ready_in;
    assign phv_valid_out = drain;
    assign key_valid_out = drain;

    // slot frees on the edge after the pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_full <= 1'b0;
        end else if (exe_valid) begin
            res_full <= 1'b1;
        end else if (drain) begin
            res_full <= 1'b0;
        end
    end

    // held until the next item comes in
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            phv_out <= exe_item.phv;
            key_out <= masked_key;
        end
    end

endmodule

// ==== source/key_extract.sv ====
`timescale 1ns/1ps

module key_extract
    import key_extract_pkg::*;
#(
    parameter int TABLE_DEPTH = 32
) (
    input  logic    clk,
    input  logic    rst_n,
    input  phv_t    phv_in,
    input  logic    phv_valid_in,
    output logic    ready_out,
    input  vid_t    vid_in,
    input  logic    vid_empty,
    output logic    vid_rd_en,
    input  tbl_wr_t tbl_wr,
    output phv_t    phv_out,
    output logic    phv_valid_out,
    output key_t    key_out,
    output logic    key_valid_out,
    input  logic    ready_in
);

    logic         dec_valid;
    decode_item_t dec_item;
    logic         exe_full;
    logic         exe_valid;
    result_item_t exe_item;
    logic         res_full;

    // ========================================
    // table lookup and phv acceptance
    // ========================================
    key_decode #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) u_key_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid_in (phv_valid_in),
        .ready_out    (ready_out),
        .vid_in       (vid_in),
        .vid_empty    (vid_empty),
        .vid_rd_en    (vid_rd_en),
        .tbl_wr       (tbl_wr),
        .exe_full     (exe_full),
        .dec_valid    (dec_valid),
        .dec_item     (dec_item)
    );

    // container select and comparator
    key_execute u_key_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_item  (dec_item),
        .res_full  (res_full),
        .exe_full  (exe_full),
        .exe_valid (exe_valid),
        .exe_item  (exe_item)
    );

    // masking and output hold
    key_result u_key_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .exe_valid     (exe_valid),
        .exe_item      (exe_item),
        .ready_in      (ready_in),
        .res_full      (res_full),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out)
    );

endmodule

// ==== verification/key_extract_tests.svh ====
// ========================================
// directed tests
// ========================================
task automatic reset_state();
    check_bit("ready_out", 1'b0, ready_out);
    check_bit("vid_rd_en", 1'b0, vid_rd_en);
    check_bit("key_valid_out", 1'b0, key_valid_out);
    check_bit("phv_valid_out", 1'b0, phv_valid_out);
    // phv offered but fifo empty
    phv_valid_in <= 1'b1;
    repeat (5) begin
        @(posedge clk);
        check_bit("ready_out", 1'b0, ready_out);
        check_bit("vid_rd_en", 1'b0, vid_rd_en);
    end
    phv_valid_in <= 1'b0;
endtask

task automatic extract_containers();
    key_off_t    off;
    logic [31:0] r;
    for (int i = 0; i < 20; i++) begin
        off        = rand_off();
        off.cmp.op = CMP_TRUE;
        r          = lcg_next();
        write_entry(tbl_idx_t'(i), off, '0);
        send(rand_phv(), make_vid(tbl_idx_t'(i), r[3:0]));
        wait_drain();
    end
    if (pops != accepts) begin
        report_error($sformatf("Mismatch at %0t: vid_rd_en pulses expected %0d got %0d",
            $time, accepts, pops));
    end
endtask

// immediate, equal and container operands of each kind
task automatic compare_operands();
    key_off_t    off;
    logic [31:0] r;
    for (int o = 0; o < 3; o++) begin
        for (int m = 0; m < 6; m++) begin
            off                = rand_off();
            off.cmp.op         = cmp_op_e'(o);
            r                  = lcg_next();
            off.cmp.operand_2  = '{is_imm: 1'b1, payload: r[7:0]};
            case (m)
                0: off.cmp.operand_1 = '{is_imm: 1'b1, payload: r[15:8]};
                1: off.cmp.operand_1 = off.cmp.operand_2;
                default: begin
                    off.cmp.operand_1 = '{is_imm: 1'b0,
                        payload: {3'b000, 2'(m - 2), r[18:16]}};
                    off.cmp.operand_2 = '{is_imm: 1'b0,
                        payload: {3'b000, 2'(5 - m), r[21:19]}};
                end
            endcase
            write_entry(tbl_idx_t'(8 + m), off, '0);
            send(rand_phv(), make_vid(tbl_idx_t'(8 + m), r[27:24]));
            wait_drain();
        end
    end
endtask

task automatic mask_key_bits();
    key_t        mask;
    logic [31:0] r;
    for (int i = 0; i < 12; i++) begin
        mask = rand_key();
        r    = lcg_next();
        write_entry(tbl_idx_t'(20 + i), rand_off(), mask);
        send(rand_phv(), make_vid(tbl_idx_t'(20 + i), r[3:0]));
        wait_drain();
        check_key("key_out masked bits", '0, key_out & mask);
    end
endtask

task automatic select_by_index();
    int idx_list [4] = '{0, 5, 17, 31};
    for (int i = 0; i < 4; i++) begin
        write_entry(tbl_idx_t'(idx_list[i]), rand_off(), '0);
    end
    // low nibble must not change the entry
    for (int i = 0; i < 4; i++) begin
        send(rand_phv(), make_vid(tbl_idx_t'(idx_list[i]), 4'h0));
        wait_drain();
        send(rand_phv(), make_vid(tbl_idx_t'(idx_list[i]), 4'hf));
        wait_drain();
    end
endtask

task automatic stall_outputs();
    @(posedge clk);
    ready_in <= 1'b0;
    send(rand_phv(), make_vid(5'd5, 4'h1));
    send(rand_phv(), make_vid(5'd17, 4'h2));
    // third phv waits on a full stage
    offer(rand_phv(), make_vid(5'd31, 4'h3));
    repeat (8) begin
        @(posedge clk);
        check_bit("ready_out", 1'b0, ready_out);
        check_bit("key_valid_out", 1'b0, key_valid_out);
    end
    ready_in <= 1'b1;
    await_accept();
    wait_drain();
endtask

// ==== verification/key_extract_tb.sv ====
`timescale 1ns/1ps

module key_extract_tb
    import key_extract_pkg::*;
;

    localparam int MAX_CYCLES = 4000;

    logic    clk;
    logic    rst_n;
    phv_t    phv_in;
    logic    phv_valid_in;
    logic    ready_out;
    vid_t    vid_in;
    logic    vid_empty;
    logic    vid_rd_en;
    tbl_wr_t tbl_wr;
    phv_t    phv_out;
    logic    phv_valid_out;
    key_t    key_out;
    logic    key_valid_out;
    logic    ready_in;

    key_t        exp_key_q [$];
    phv_t        exp_phv_q [$];
    key_off_t    shadow_off [32];
    key_t        shadow_mask [32];
    logic [31:0] lcg_state = 32'd60007;
    int          accepts;
    int          pops;
    int          cycles;

    key_extract #(
        .TABLE_DEPTH (32)
    ) u_key_extract (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .ready_out     (ready_out),
        .vid_in        (vid_in),
        .vid_empty     (vid_empty),
        .vid_rd_en     (vid_rd_en),
        .tbl_wr        (tbl_wr),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .ready_in      (ready_in)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // error reporting and compares
    // ========================================
    task automatic report_error(string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_key(string name, key_t exp, key_t act);
        if (act !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s expected %h got %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_phv(string name, phv_t exp, phv_t act);
        if (act !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s expected %h got %h",
                $time, name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            report_error($sformatf("Mismatch at %0t: %s expected %b got %b",
                $time, name, exp, act));
        end
    endtask

    // ========================================
    // random values
    // ========================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // upper half has the better bits
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic phv_t rand_phv();
        logic [$bits(phv_t)-1:0] v;
        for (int i = 0; i < $bits(phv_t) / 32; i++) begin
            v[i*32 +: 32] = lcg_next();
        end
        return phv_t'(v);
    endfunction

    function automatic key_t rand_key();
        logic [223:0] v;
        for (int i = 0; i < 7; i++) begin
            v[i*32 +: 32] = lcg_next();
        end
        return v[KEY_W-1:0];
    endfunction

    function automatic key_off_t rand_off();
        logic [63:0] v;
        v = {lcg_next(), lcg_next()};
        return key_off_t'(v[$bits(key_off_t)-1:0]);
    endfunction

    function automatic vid_t make_vid(tbl_idx_t idx, logic [3:0] nib);
        return {3'b101, idx, nib};
    endfunction

    // ========================================
    // reference model
    // ========================================
    function automatic cmp_byte_t operand_value(cmp_operand_t o, phv_t p);
        logic [2:0] idx;
        idx = o.payload[2:0];
        if (o.is_imm) begin
            return o.payload;
        end
        case (o.payload[4:3])
            2'd0:    return p.cont2[idx][7:0];
            2'd1:    return p.cont4[idx][7:0];
            2'd2:    return p.cont6[idx][7:0];
            default: return 8'h00;
        endcase
    endfunction

    function automatic key_t expected_key(phv_t p, key_off_t off, key_t mask);
        key_fields_t f;
        cmp_byte_t   a;
        cmp_byte_t   b;
        a = operand_value(off.cmp.operand_1, p);
        b = operand_value(off.cmp.operand_2, p);
        f.six_a  = p.cont6[off.sel_six_a];
        f.six_b  = p.cont6[off.sel_six_b];
        f.four_a = p.cont4[off.sel_four_a];
        f.four_b = p.cont4[off.sel_four_b];
        f.two_a  = p.cont2[off.sel_two_a];
        f.two_b  = p.cont2[off.sel_two_b];
        if (off.cmp.op == CMP_GT) begin
            f.cmp_bit = (a > b);
        end else if (off.cmp.op == CMP_GE) begin
            f.cmp_bit = (a >= b);
        end else if (off.cmp.op == CMP_EQ) begin
            f.cmp_bit = (a == b);
        end else begin
            f.cmp_bit = 1'b1;
        end
        return key_t'(f) & ~mask;
    endfunction

    // ========================================
    // drivers
    // ========================================
    task automatic write_entry(tbl_idx_t idx, key_off_t off, key_t mask);
        @(posedge clk);
        tbl_wr <= '{wr_off: 1'b1, wr_mask: 1'b1, index: idx, off: off, mask: mask};
        shadow_off[idx]  = off;
        shadow_mask[idx] = mask;
        @(posedge clk);
        tbl_wr <= '0;
    endtask

    // present a phv with its vid at the fifo head
    task automatic offer(phv_t p, vid_t vid);
        tbl_idx_t idx;
        idx = vid[VID_INDEX_LSB +: TBL_IDX_W];
        @(posedge clk);
        exp_key_q.push_back(expected_key(p, shadow_off[idx], shadow_mask[idx]));
        exp_phv_q.push_back(p);
        phv_in       <= p;
        vid_in       <= vid;
        vid_empty    <= 1'b0;
        phv_valid_in <= 1'b1;
    endtask

    task automatic await_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (!ready_out) begin
            n++;
            if (n > 40) begin
                report_error("PHV was not accepted within 40 cycles");
            end
            @(posedge clk);
        end
        check_bit("vid_rd_en", 1'b1, vid_rd_en);
        accepts++;
        phv_valid_in <= 1'b0;
        vid_empty    <= 1'b1;
    endtask

    task automatic send(phv_t p, vid_t vid);
        offer(p, vid);
        await_accept();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_key_q.size() > 0) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                report_error("no valid pulse arrived within 20 cycles of acceptance");
            end
        end
    endtask

    `include "key_extract_tests.svh"

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (vid_rd_en) begin
                pops++;
            end
            if (key_valid_out || phv_valid_out) begin
                check_bit("key_valid_out", 1'b1, key_valid_out);
                check_bit("phv_valid_out", 1'b1, phv_valid_out);
                if (!ready_in) begin
                    report_error("valid pulse appeared while ready_in was low");
                end
                if (exp_key_q.size() == 0) begin
                    report_error("valid pulse seen with no PHV outstanding");
                end else begin
                    check_key("key_out", exp_key_q.pop_front(), key_out);
                    check_phv("phv_out", exp_phv_q.pop_front(), phv_out);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_error($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        vid_in       = '0;
        vid_empty    = 1'b1;
        tbl_wr       = '0;
        ready_in     = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_state();
        extract_containers();
        compare_operands();
        mask_key_bits();
        select_by_index();
        stall_outputs();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verification
source/key_extract_pkg.sv
source/key_table.sv
source/key_decode.sv
source/key_execute.sv
source/key_result.sv
source/key_extract.sv
verification/key_extract_tb.sv
